// ==== fp_regfile_sub.f ====
hdl/fpu_pkg.sv
hdl/reg_file.sv
hdl/rv_float_reg_file.sv
hdl/fp_cmd_axil_slave.sv
hdl/fp_cmd_fifo.sv
hdl/fp_exec_unit.sv
hdl/fp_regfile_sub_top.sv
tb/fp_sub_checker.sv
tb/tb_fp_regfile_sub.sv

// ==== hdl/fp_cmd_axil_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_cmd_axil_slave import fpu_pkg::*; #(
  parameter int FIFO_DEPTH = 4  // command fifo depth
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic [7:0]                        awaddr_i,
  input  logic                              awvalid_i,
  output logic                              awready_o,
  input  logic [31:0]                       wdata_i,
  input  logic [3:0]                        wstrb_i,
  input  logic                              wvalid_i,
  output logic                              wready_o,
  output logic [1:0]                        bresp_o,
  output logic                              bvalid_o,
  input  logic                              bready_i,
  input  logic [7:0]                        araddr_i,
  input  logic                              arvalid_i,
  output logic                              arready_o,
  output logic [31:0]                       rdata_o,
  output logic [1:0]                        rresp_o,
  output logic                              rvalid_o,
  input  logic                              rready_i,
  output logic                              push_o,       // fifo write strobe
  output fp_cmd_t                           cmd_o,        // packed command
  input  logic                              full_i,       // fifo full
  input  logic [$clog2(FIFO_DEPTH+1)-1:0]   count_i,      // fifo occupancy
  input  logic                              busy_i,       // exec write pending
  output logic [4:0]                        freg_addr_o,  // rs3 address
  input  logic [31:0]                       freg_data_i   // rs3 data
);

  logic        wr_rdy_q, bvalid_q, wr_hs, wr_is_cmd;
  logic        ar_en_q, rvalid_q, ar_hs;
  logic [31:0] stage_q, rdata_q, rd_mux, status_word;

  //////////////////////////////
  // write channel
  //////////////////////////////

  assign wr_is_cmd = (awaddr_i == ADDR_CMD);
  assign wr_hs     = wr_rdy_q & awvalid_i & wvalid_i;  // aw and w taken together

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_rdy_q <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      // single cycle ready pulse, blocked by pending b or full fifo
      wr_rdy_q <= ~wr_rdy_q & awvalid_i & wvalid_i & ~bvalid_q & ~(wr_is_cmd & full_i);
      if (wr_hs) begin
        bvalid_q <= 1'b1;
      end else if (bready_i) begin
        bvalid_q <= 1'b0;  // response taken
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      stage_q <= '0;  // host visible, so cleared
    end else if (wr_hs && (awaddr_i == ADDR_DATA)) begin
      for (int b = 0; b < 4; b++) begin
        if (wstrb_i[b]) stage_q[8*b +: 8] <= wdata_i[8*b +: 8];  // byte lanes
      end
    end
  end

  assign push_o     = wr_hs & wr_is_cmd;  // full already checked before ready
  assign cmd_o.op   = fp_op_e'(wdata_i[2:0]);
  assign cmd_o.rd   = wdata_i[7:3];
  assign cmd_o.rs1  = wdata_i[12:8];
  assign cmd_o.rs2  = wdata_i[17:13];
  assign cmd_o.data = stage_q;            // load value from staging

  assign awready_o = wr_rdy_q;
  assign wready_o  = wr_rdy_q;
  assign bvalid_o  = bvalid_q;
  assign bresp_o   = 2'b00;               // always okay

  //////////////////////////////
  // read channel
  //////////////////////////////

  assign status_word = {24'h0, 4'(count_i), 3'h0, (count_i != '0) | busy_i};
  assign freg_addr_o = araddr_i[6:2];  // word index above the f-reg base

  always_comb begin
    if (araddr_i >= ADDR_FREG_BASE && araddr_i[1:0] == 2'b00) begin
      rd_mux = freg_data_i;  // f register via rs3
    end else if (araddr_i == ADDR_STATUS) begin
      rd_mux = status_word;
    end else if (araddr_i == ADDR_DATA) begin
      rd_mux = stage_q;
    end else begin
      rd_mux = '0;  // unmapped
    end
  end

  assign arready_o = ar_en_q & ~rvalid_q;  // low during reset
  assign ar_hs     = arready_o & arvalid_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ar_en_q  <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      ar_en_q <= 1'b1;
      if (ar_hs) begin
        rvalid_q <= 1'b1;
      end else if (rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_hs) rdata_q <= rd_mux;  // sampled at acceptance
  end

  assign rdata_o  = rdata_q;
  assign rvalid_o = rvalid_q;
  assign rresp_o  = 2'b00;

endmodule

`default_nettype wire

// ==== hdl/fp_cmd_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_cmd_fifo import fpu_pkg::*; #(
  parameter int FIFO_DEPTH = 4  // entries
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            push_i,   // write strobe
  input  fp_cmd_t                         cmd_i,    // entry in
  input  logic                            pop_i,    // read strobe
  output fp_cmd_t                         cmd_o,    // head entry
  output logic                            valid_o,  // head is valid
  output logic                            full_o,
  output logic [$clog2(FIFO_DEPTH+1)-1:0] count_o
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  fp_cmd_t          mem_q [FIFO_DEPTH];  // entry storage
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push, do_pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;  // wrap for any depth
  endfunction

  assign do_push = push_i & ~full_o;  // overflow dropped
  assign do_pop  = pop_i & valid_o;   // underflow ignored

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (do_pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // both or neither
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= cmd_i;
  end

  assign cmd_o   = mem_q[rd_ptr_q];  // show-ahead head
  assign valid_o = (count_q != '0);
  assign full_o  = (count_q == CNT_W'(FIFO_DEPTH));
  assign count_o = count_q;

endmodule

`default_nettype wire

// ==== hdl/fp_exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_exec_unit import fpu_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  fp_cmd_t     cmd_i,       // fifo head
  input  logic        valid_i,     // head valid
  output logic        pop_o,       // consume head
  output logic [4:0]  rs1_addr_o,
  output logic [4:0]  rs2_addr_o,
  input  logic [31:0] rs1_data_i,
  input  logic [31:0] rs2_data_i,
  output logic [4:0]  rd_addr_o,   // registered write
  output logic [31:0] rd_data_o,
  output logic        rd_en_o,
  output logic        busy_o       // write in flight
);

  logic        rd_en_q, wr_en;
  logic [4:0]  rd_addr_q;
  logic [31:0] rd_data_q, a, b, res;
  logic        a_nan, b_nan, a_lt_b;

  assign pop_o      = valid_i;  // one command per cycle, no stall
  assign rs1_addr_o = cmd_i.rs1;
  assign rs2_addr_o = cmd_i.rs2;

  // bypass the write still in flight to the file
  assign a = (rd_en_q && rd_addr_q == cmd_i.rs1) ? rd_data_q : rs1_data_i;
  assign b = (rd_en_q && rd_addr_q == cmd_i.rs2) ? rd_data_q : rs2_data_i;

  //////////////////////////////
  // min / max compare
  //////////////////////////////

  assign a_nan = (a[30:23] == 8'hFF) && (a[22:0] != '0);
  assign b_nan = (b[30:23] == 8'hFF) && (b[22:0] != '0);

  always_comb begin
    if (a[31] != b[31]) begin
      a_lt_b = a[31];  // negative side lower, -0 below +0 too
    end else if (!a[31]) begin
      a_lt_b = a[30:0] < b[30:0];  // both positive, magnitude order
    end else begin
      a_lt_b = a[30:0] > b[30:0];  // both negative, reversed
    end
  end

  always_comb begin
    wr_en = 1'b1;
    res   = '0;
    case (cmd_i.op)
      FP_LOAD:  res = cmd_i.data;
      FP_SGNJ:  res = {b[31], a[30:0]};
      FP_SGNJN: res = {~b[31], a[30:0]};
      FP_SGNJX: res = {a[31] ^ b[31], a[30:0]};
      FP_MIN, FP_MAX: begin
        if (a_nan && b_nan) res = CANON_NAN;
        else if (a_nan)     res = b;  // drop the nan
        else if (b_nan)     res = a;
        else                res = (a_lt_b == (cmd_i.op == FP_MIN)) ? a : b;
      end
      default:  wr_en = 1'b0;  // 6 and 7 leave the file alone
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) rd_en_q <= 1'b0;
    else          rd_en_q <= valid_i & wr_en;
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      rd_addr_q <= cmd_i.rd;
      rd_data_q <= res;
    end
  end

  assign rd_addr_o = rd_addr_q;
  assign rd_data_o = rd_data_q;
  assign rd_en_o   = rd_en_q;
  assign busy_o    = rd_en_q;  // file updates at the end of this cycle

endmodule

`default_nettype wire

// ==== hdl/fp_regfile_sub_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_regfile_sub_top import fpu_pkg::*; #(
  parameter int FLEN       = 32,  // only 32 supported
  parameter int FIFO_DEPTH = 4
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic [7:0]  s_axil_awaddr_i,
  input  logic        s_axil_awvalid_i,
  output logic        s_axil_awready_o,
  input  logic [31:0] s_axil_wdata_i,
  input  logic [3:0]  s_axil_wstrb_i,
  input  logic        s_axil_wvalid_i,
  output logic        s_axil_wready_o,
  output logic [1:0]  s_axil_bresp_o,
  output logic        s_axil_bvalid_o,
  input  logic        s_axil_bready_i,
  input  logic [7:0]  s_axil_araddr_i,
  input  logic        s_axil_arvalid_i,
  output logic        s_axil_arready_o,
  output logic [31:0] s_axil_rdata_o,
  output logic [1:0]  s_axil_rresp_o,
  output logic        s_axil_rvalid_o,
  input  logic        s_axil_rready_i
);

  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  fp_cmd_t          push_cmd, head_cmd;            // slave -> fifo -> exec
  logic             push, pop, head_valid, full, busy, rd_en;
  logic [CNT_W-1:0] count;
  logic [4:0]       rs1_addr, rs2_addr, rs3_addr, rd_addr;
  logic [FLEN-1:0]  rs1_data, rs2_data, rs3_data, rd_data;

  fp_cmd_axil_slave #(.FIFO_DEPTH(FIFO_DEPTH)) u_slave (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .awaddr_i(s_axil_awaddr_i), .awvalid_i(s_axil_awvalid_i), .awready_o(s_axil_awready_o),
    .wdata_i(s_axil_wdata_i), .wstrb_i(s_axil_wstrb_i), .wvalid_i(s_axil_wvalid_i),
    .wready_o(s_axil_wready_o), .bresp_o(s_axil_bresp_o), .bvalid_o(s_axil_bvalid_o),
    .bready_i(s_axil_bready_i), .araddr_i(s_axil_araddr_i), .arvalid_i(s_axil_arvalid_i),
    .arready_o(s_axil_arready_o), .rdata_o(s_axil_rdata_o), .rresp_o(s_axil_rresp_o),
    .rvalid_o(s_axil_rvalid_o), .rready_i(s_axil_rready_i),
    .push_o(push), .cmd_o(push_cmd), .full_i(full), .count_i(count), .busy_i(busy),
    .freg_addr_o(rs3_addr), .freg_data_i(rs3_data)
  );

  fp_cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .push_i(push), .cmd_i(push_cmd), .pop_i(pop),
    .cmd_o(head_cmd), .valid_o(head_valid), .full_o(full), .count_o(count)
  );

  fp_exec_unit u_exec (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .cmd_i(head_cmd), .valid_i(head_valid), .pop_o(pop),
    .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr), .rs1_data_i(rs1_data),
    .rs2_data_i(rs2_data), .rd_addr_o(rd_addr), .rd_data_o(rd_data), .rd_en_o(rd_en),
    .busy_o(busy)
  );

  rv_float_reg_file #(.FLEN(FLEN)) u_freg (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .rd_addr_i(rd_addr), .rd_data_i(rd_data),
    .rd_en_i(rd_en), .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr), .rs3_addr_i(rs3_addr),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data), .rs3_data_o(rs3_data)
  );

endmodule

`default_nettype wire

// ==== hdl/fpu_pkg.sv ====
`default_nettype none

package fpu_pkg;

  //////////////////////////////
  // opcodes and command word
  //////////////////////////////

  typedef enum logic [2:0] {
    FP_LOAD  = 3'd0,  // rd <- staged data
    FP_SGNJ  = 3'd1,  // sign of rs2
    FP_SGNJN = 3'd2,  // inverted sign of rs2
    FP_SGNJX = 3'd3,  // xor of both signs
    FP_MIN   = 3'd4,  // ieee minimum
    FP_MAX   = 3'd5   // ieee maximum
  } fp_op_e;          // 6 and 7 unused, no write

  typedef struct packed {
    fp_op_e      op;    // operation
    logic [4:0]  rd;    // destination
    logic [4:0]  rs1;   // source 1
    logic [4:0]  rs2;   // source 2
    logic [31:0] data;  // staged load value
  } fp_cmd_t;           // 50 bits, one fifo entry

  //////////////////////////////
  // register map
  //////////////////////////////

  localparam logic [7:0] ADDR_CMD       = 8'h00;  // push command
  localparam logic [7:0] ADDR_STATUS    = 8'h04;  // busy and fifo count
  localparam logic [7:0] ADDR_DATA      = 8'h08;  // staging register
  localparam logic [7:0] ADDR_FREG_BASE = 8'h80;  // f0 here, fN at base + 4N

  localparam logic [31:0] CANON_NAN = 32'h7FC0_0000;  // riscv canonical qnan

endpackage

`default_nettype wire

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
  parameter int NUM_RS    = 2,   // number of read ports
  parameter bit ZERO_REG  = 1,   // register 0 hardwired to zero
  parameter int NUM_REG   = 32,  // number of registers
  parameter int REG_WIDTH = 32   // bits per register
) (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  logic [$clog2(NUM_REG)-1:0]                    rd_addr_i,  // write address
  input  logic [REG_WIDTH-1:0]                          rd_data_i,  // write data
  input  logic                                          rd_en_i,    // write enable
  input  logic [NUM_RS-1:0][$clog2(NUM_REG)-1:0]        rs_addr_i,  // one address per port
  output logic [NUM_RS-1:0][REG_WIDTH-1:0]              rs_data_o   // one word per port
);

  logic [NUM_REG-1:0][REG_WIDTH-1:0] regs_q;  // storage
  logic                              wr_ok;   // write allowed

  // writes to x0 dropped only when zero reg is on
  assign wr_ok = rd_en_i & ~(ZERO_REG && (rd_addr_i == '0));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      regs_q <= '0;  // all registers start at zero
    end else if (wr_ok) begin
      regs_q[rd_addr_i] <= rd_data_i;
    end
  end

  //////////////////////////////
  // read ports
  //////////////////////////////

  for (genvar p = 0; p < NUM_RS; p++) begin : g_rd_port
    always_comb begin
      if (ZERO_REG && (rs_addr_i[p] == '0)) begin
        rs_data_o[p] = '0;  // x0 always reads zero
      end else begin
        rs_data_o[p] = regs_q[rs_addr_i[p]];  // plain async read
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rv_float_reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_float_reg_file #(
  parameter int FLEN = 32  // float register width
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic [4:0]      rd_addr_i,   // destination address
  input  logic [FLEN-1:0] rd_data_i,   // write data
  input  logic            rd_en_i,     // write enable
  input  logic [4:0]      rs1_addr_i,  // source 1 address
  input  logic [4:0]      rs2_addr_i,  // source 2 address
  input  logic [4:0]      rs3_addr_i,  // source 3 address
  output logic [FLEN-1:0] rs1_data_o,  // source 1 data
  output logic [FLEN-1:0] rs2_data_o,  // source 2 data
  output logic [FLEN-1:0] rs3_data_o   // source 3 data
);

  localparam int NUM_REG = 32;  // f0..f31, f0 is an ordinary register

  logic [2:0][4:0]      rs_addr;  // packed port addresses
  logic [2:0][FLEN-1:0] rs_data;  // packed port data

  // each source owns its own slot
  assign rs_addr[0] = rs1_addr_i;
  assign rs_addr[1] = rs2_addr_i;
  assign rs_addr[2] = rs3_addr_i;
  assign rs1_data_o = rs_data[0];
  assign rs2_data_o = rs_data[1];
  assign rs3_data_o = rs_data[2];

  reg_file #(
    .NUM_RS   (3),
    .ZERO_REG (1'b0),
    .NUM_REG  (NUM_REG),
    .REG_WIDTH(FLEN)
  ) u_reg_file (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .rd_addr_i(rd_addr_i),
    .rd_data_i(rd_data_i),
    .rd_en_i  (rd_en_i),
    .rs_addr_i(rs_addr),
    .rs_data_o(rs_data)
  );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_fp_regfile_sub \
  -f fp_regfile_sub.f

out="$(./obj_dir/Vtb_fp_regfile_sub)"
echo "$out"

# exit status follows the pass line
echo "$out" | grep -qx '\*\* PASS \*\*'

// ==== tb/fp_sub_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_sub_checker import fpu_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic [7:0]  awaddr_i,
  input  logic        awvalid_i,
  input  logic        awready_i,
  input  logic [31:0] wdata_i,
  input  logic [3:0]  wstrb_i,
  input  logic        wvalid_i,
  input  logic        wready_i,
  input  logic [1:0]  bresp_i,
  input  logic        bvalid_i,
  input  logic        bready_i,
  input  logic [7:0]  araddr_i,
  input  logic        arvalid_i,
  input  logic        arready_i,
  input  logic [31:0] rdata_i,
  input  logic [1:0]  rresp_i,
  input  logic        rvalid_i,
  input  logic        rready_i,
  output int          value_errors_o,
  output int          proto_errors_o,
  output int          checks_o
);

  localparam int RESP_LIMIT = 32;  // cycles allowed for b or r

  logic [31:0] model [32];  // expected f registers
  logic [31:0] stage;       // expected staging register
  logic [2:0]  op_q [$];    // opcodes queued in the fifo
  logic [2:0]  head_op;     // opcode executed at this edge
  logic        exec_wr;     // file write lands this cycle
  logic [31:0] exp_rdata;
  logic [32:0] res;         // {write, value}
  logic [7:0]  rd_addr;
  logic        rd_pend, wr_pend;
  int          rd_age, wr_age;
  int          value_errors = 0;
  int          proto_errors = 0;
  int          checks = 0;

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic logic is_nan(input logic [31:0] x);
    return (x[30:23] == 8'hFF) && (x[22:0] != '0);
  endfunction

  // unsigned key that sorts floats in ieee order, -0 just below +0
  function automatic logic [31:0] order_key(input logic [31:0] x);
    return x[31] ? ~x : {1'b1, x[30:0]};
  endfunction

  function automatic logic [32:0] ref_result(input logic [2:0] op, input logic [31:0] a,
                                             input logic [31:0] b, input logic [31:0] data);
    logic a_first;
    a_first = order_key(a) <= order_key(b);  // a is the smaller one
    case (op)
      FP_LOAD:  return {1'b1, data};
      FP_SGNJ:  return {1'b1, b[31], a[30:0]};
      FP_SGNJN: return {1'b1, ~b[31], a[30:0]};
      FP_SGNJX: return {1'b1, a[31] ^ b[31], a[30:0]};
      FP_MIN, FP_MAX: begin
        if (is_nan(a) && is_nan(b)) return {1'b1, CANON_NAN};
        if (is_nan(a)) return {1'b1, b};  // other operand wins
        if (is_nan(b)) return {1'b1, a};
        return {1'b1, (a_first == (op == FP_MIN)) ? a : b};
      end
      default:  return {1'b0, 32'h0};  // undefined opcode, no write
    endcase
  endfunction

  function automatic logic [31:0] expected_read(input logic [7:0] addr);
    if (addr[7] && addr[1:0] == 2'b00) return model[addr[6:2]];
    if (addr == ADDR_DATA) return stage;
    if (addr == ADDR_STATUS) begin
      return {24'h0, 4'(op_q.size()), 3'h0, (op_q.size() != 0) || exec_wr};
    end
    return '0;  // cmd and unmapped
  endfunction

  //////////////////////////////
  // bus monitor
  //////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 32; i++) model[i] = '0;
      op_q.delete();
      stage   = '0;
      exec_wr = 1'b0;
      rd_pend = 1'b0;
      wr_pend = 1'b0;
    end else begin
      if (rvalid_i && rready_i) begin
        checks++;
        if (!rd_pend) begin
          $display("read response arrived with no read outstanding");
          proto_errors++;
        end else if (rdata_i != exp_rdata) begin
          $display("FAILED s_axil_rdata_o @%02h expected %08h actual %08h",
                   rd_addr, exp_rdata, rdata_i);
          value_errors++;
        end
        if (rresp_i != 2'b00) begin
          $display("read response was not OKAY");
          proto_errors++;
        end
        rd_pend = 1'b0;
      end
      if (arvalid_i && arready_i) begin
        exp_rdata = expected_read(araddr_i);
        rd_addr   = araddr_i;
        rd_pend   = 1'b1;
        rd_age    = 0;
      end else if (rd_pend) begin
        rd_age++;
        if (rd_age > RESP_LIMIT) begin
          $display("read of address %02h got no response", rd_addr);
          proto_errors++;
          rd_pend = 1'b0;
        end
      end
      // head leaves the fifo every cycle and writes one cycle later
      exec_wr = 1'b0;
      if (op_q.size() != 0) begin
        head_op = op_q.pop_front();
        exec_wr = (head_op <= FP_MAX);  // 6 and 7 write nothing
      end
      if (bvalid_i && bready_i) begin
        if (!wr_pend || bresp_i != 2'b00) begin
          $display("write response was unexpected or not OKAY");
          proto_errors++;
        end
        wr_pend = 1'b0;
      end
      if (awvalid_i && awready_i && wvalid_i && wready_i) begin
        if (awaddr_i == ADDR_DATA) begin
          for (int b = 0; b < 4; b++) begin
            if (wstrb_i[b]) stage[8*b +: 8] = wdata_i[8*b +: 8];
          end
        end else if (awaddr_i == ADDR_CMD) begin
          res = ref_result(wdata_i[2:0], model[wdata_i[12:8]], model[wdata_i[17:13]], stage);
          if (res[32]) model[wdata_i[7:3]] = res[31:0];
          op_q.push_back(wdata_i[2:0]);  // visible at the head after this edge
        end
        wr_pend = 1'b1;
        wr_age  = 0;
      end else if (wr_pend) begin
        wr_age++;
        if (wr_age > RESP_LIMIT) begin
          $display("write got no response");
          proto_errors++;
          wr_pend = 1'b0;
        end
      end
    end
  end

  assign value_errors_o = value_errors;
  assign proto_errors_o = proto_errors;
  assign checks_o       = checks;

endmodule

`default_nettype wire

// ==== tb/tb_fp_regfile_sub.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fp_regfile_sub import fpu_pkg::*; ();

  localparam int CLK_PERIOD    = 100;
  localparam int FIFO_DEPTH    = 4;
  localparam int PLANNED_TRANS = 520;  // all axi transfers of the sequence, with polls

  logic        clk, rst_n;
  logic [7:0]  awaddr, araddr;
  logic [31:0] wdata, rdata;
  logic [3:0]  wstrb;
  logic        awvalid, awready, wvalid, wready, bvalid, bready;
  logic        arvalid, arready, rvalid, rready;
  logic [1:0]  bresp, rresp;
  int          stalls = 0;  // handshakes that never completed
  int          value_errors, proto_errors, checks;

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  fp_regfile_sub_top #(.FLEN(32), .FIFO_DEPTH(FIFO_DEPTH)) dut0 (
    .clk_i(clk), .rst_n_i(rst_n),
    .s_axil_awaddr_i(awaddr), .s_axil_awvalid_i(awvalid), .s_axil_awready_o(awready),
    .s_axil_wdata_i(wdata), .s_axil_wstrb_i(wstrb), .s_axil_wvalid_i(wvalid),
    .s_axil_wready_o(wready), .s_axil_bresp_o(bresp), .s_axil_bvalid_o(bvalid),
    .s_axil_bready_i(bready), .s_axil_araddr_i(araddr), .s_axil_arvalid_i(arvalid),
    .s_axil_arready_o(arready), .s_axil_rdata_o(rdata), .s_axil_rresp_o(rresp),
    .s_axil_rvalid_o(rvalid), .s_axil_rready_i(rready)
  );

  fp_sub_checker chk0 (
    .clk_i(clk), .rst_n_i(rst_n), .awaddr_i(awaddr), .awvalid_i(awvalid),
    .awready_i(awready), .wdata_i(wdata), .wstrb_i(wstrb), .wvalid_i(wvalid),
    .wready_i(wready), .bresp_i(bresp), .bvalid_i(bvalid), .bready_i(bready),
    .araddr_i(araddr), .arvalid_i(arvalid), .arready_i(arready), .rdata_i(rdata),
    .rresp_i(rresp), .rvalid_i(rvalid), .rready_i(rready),
    .value_errors_o(value_errors), .proto_errors_o(proto_errors), .checks_o(checks)
  );

  //////////////////////////////
  // axi4-lite host tasks
  //////////////////////////////

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
    int n;
    n = 0;
    @(posedge clk);
    awaddr  <= addr;
    wdata   <= data;
    wstrb   <= 4'hF;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    do begin
      @(negedge clk);  // ready sampled mid cycle
      n++;
    end while (!(awready && wready) && n < 50);
    if (!(awready && wready)) begin
      $display("write to %02h was never accepted", addr);
      stalls++;
    end
    @(posedge clk);  // handshake edge
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!bvalid && n < 50);  // missing b flagged by the checker
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
    int n;
    n = 0;
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    do begin
      @(negedge clk);
      n++;
    end while (!arready && n < 50);
    if (!arready) begin
      $display("read of %02h was never accepted", addr);
      stalls++;
    end
    @(posedge clk);
    arvalid <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!rvalid && n < 50);
    data = rdata;
  endtask

  task automatic issue(input logic [2:0] op, input logic [4:0] rd, input logic [4:0] rs1,
                       input logic [4:0] rs2);
    axi_write(ADDR_CMD, {14'h0, rs2, rs1, rd, op});  // command word layout
  endtask

  task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
    axi_write(ADDR_DATA, value);  // stage first
    issue(FP_LOAD, rd, 5'd0, 5'd0);
  endtask

  task automatic read_reg(input int n);
    logic [31:0] d;
    axi_read(8'(int'(ADDR_FREG_BASE) + 4 * n), d);  // value checked by chk0
  endtask

  task automatic read_all_regs();
    for (int i = 0; i < 32; i++) read_reg(i);
  endtask

  task automatic wait_idle();
    logic [31:0] st;
    int n;
    n = 0;
    do begin
      axi_read(ADDR_STATUS, st);
      n++;
    end while (st[0] && n < 100);
    if (st[0]) begin
      $display("status never returned to idle");
      stalls++;
    end
  endtask

  // min and max in both operand orders
  task automatic minmax_pair(input logic [31:0] a, input logic [31:0] b);
    load_reg(5'd1, a);
    load_reg(5'd2, b);
    issue(FP_MIN, 5'd3, 5'd1, 5'd2);
    issue(FP_MAX, 5'd4, 5'd1, 5'd2);
    issue(FP_MIN, 5'd5, 5'd2, 5'd1);
    issue(FP_MAX, 5'd6, 5'd2, 5'd1);
    wait_idle();
    for (int i = 3; i <= 6; i++) read_reg(i);
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    logic [31:0] d;
    logic [4:0]  rd;
    void'($urandom(39731));
    rst_n    = 1'b0;
    awaddr   = '0;
    wdata    = '0;
    wstrb    = '0;
    awvalid  = 1'b0;
    wvalid   = 1'b0;
    bready   = 1'b0;
    araddr   = '0;
    arvalid  = 1'b0;
    rready   = 1'b0;
    repeat (4) @(posedge clk);
    rst_n  <= 1'b1;
    bready <= 1'b1;  // host always takes responses
    rready <= 1'b1;

    read_all_regs();  // reset values
    axi_read(ADDR_STATUS, d);

    for (int i = 0; i < 32; i++) load_reg(5'(i), $urandom());
    wait_idle();
    read_all_regs();

    for (int i = 0; i < 24; i++) begin
      rd = 5'($urandom());
      issue(3'($urandom_range(3, 1)), rd, (i % 4 == 0) ? rd : 5'($urandom()), 5'($urandom()));
    end
    wait_idle();
    read_all_regs();

    for (int i = 0; i < 24; i++) begin
      issue(3'($urandom_range(5, 4)), 5'($urandom()), 5'($urandom()), 5'($urandom()));
    end
    wait_idle();
    read_all_regs();
    minmax_pair(32'h0000_0000, 32'h8000_0000);  // +0 and -0
    minmax_pair(32'h7FC0_0000, 32'h3F80_0000);  // qnan and 1.0
    minmax_pair(32'h7FC0_0001, 32'hFF80_0001);  // two nans
    minmax_pair(32'h4020_0000, 32'h4020_0000);  // equal
    minmax_pair(32'hC040_0000, 32'hBFC0_0000);  // -3.0 and -1.5

    // back to back, each reading the previous result
    for (int i = 0; i < 10; i++) begin
      issue((i % 2) ? FP_SGNJX : FP_MAX, 5'(20 + i), 5'(19 + i), 5'(i));
    end
    wait_idle();
    read_all_regs();

    axi_read(8'h0C, d);  // unmapped
    axi_read(8'h10, d);
    axi_read(8'h40, d);
    axi_read(8'h7C, d);
    axi_read(8'h81, d);  // unaligned f-reg window
    axi_read(ADDR_CMD, d);
    axi_read(ADDR_DATA, d);
    issue(3'd6, 5'd5, 5'd1, 5'd2);
    issue(3'd7, 5'd9, 5'd3, 5'd4);
    wait_idle();
    read_all_regs();

    $display("errors: %0d value, %0d protocol, %0d stall, over %0d checked reads",
             value_errors, proto_errors, stalls, checks);
    if (value_errors == 0 && proto_errors == 0 && stalls == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #(PLANNED_TRANS * 40 * CLK_PERIOD);
    $display("watchdog expired before the test sequence finished");
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire
